// File: fetch_pkg.sv
package fetch_pkg;

	////////////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////////////

	// instruction and address width
	localparam int xlen = 32;
	// instruction memory depth in words
	localparam int imem_words = 256;
	// word address bits, byte address bits 9..2
	localparam int imem_aw = 8;

	// axi response code
	localparam logic [1:0] axi_okay = 2'b00;

	////////////////////////////////////////////////////////////////////
	// memory port
	////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic               valid;
		logic               write;
		logic [imem_aw-1:0] addr;
		logic [xlen-1:0]    wdata;
		logic [3:0]         strb;
	} imem_req_t;

	////////////////////////////////////////////////////////////////////
	// axi4-lite, master side and slave side
	////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic            aw_valid;
		logic [xlen-1:0] aw_addr;
		logic            w_valid;
		logic [xlen-1:0] w_data;
		logic [3:0]      w_strb;
		logic            b_ready;
		logic            ar_valid;
		logic [xlen-1:0] ar_addr;
		logic            r_ready;
	} axil_req_t;

	typedef struct packed {
		logic            aw_ready;
		logic            w_ready;
		logic            b_valid;
		logic [1:0]      b_resp;
		logic            ar_ready;
		logic            r_valid;
		logic [xlen-1:0] r_data;
		logic [1:0]      r_resp;
	} axil_rsp_t;

	////////////////////////////////////////////////////////////////////
	// fetch stream
	////////////////////////////////////////////////////////////////////

	// compressed ones sit zero-extended in the low half
	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] instr;
		logic            compressed;
	} fetch_out_t;

	// branch, jump or trap target, already computed by the core
	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] target;
	} redirect_t;

endpackage

// File: imem_ram.sv
`timescale 1ns/1ps

module imem_ram import fetch_pkg::*; (
	input  logic            bus,
	input  imem_req_t       req,
	output logic [xlen-1:0] rdata
);

	// word array, contents come from the loader
	logic [xlen-1:0] mem [0:imem_words-1];

	////////////////////////////////////////////////////////////////////
	// single port, read registered, write lands at the same edge
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge bus) begin
		if (req.valid) begin
			if (req.write) begin
				// byte lanes
				for (int i = 0; i < 4; i++) begin
					if (req.strb[i]) begin
						mem[req.addr][8*i +: 8] <= req.wdata[8*i +: 8];
					end
				end
			end else begin
				// data valid in the next cycle
				rdata <= mem[req.addr];
			end
		end
	end

endmodule

// File: imem_arbiter.sv
`timescale 1ns/1ps

module imem_arbiter import fetch_pkg::*; (
	input  logic      bus,
	input  logic      rst_n,
	input  imem_req_t load_req,
	input  imem_req_t fetch_req,
	output logic      load_gnt,
	output logic      fetch_gnt,
	output imem_req_t mem_req
);

	////////////////////////////////////////////////////////////////////
	// fixed priority with the loader first
	////////////////////////////////////////////////////////////////////

	assign load_gnt = load_req.valid;
	// fetch only on a free port and asks again when refused
	assign fetch_gnt = fetch_req.valid & ~load_req.valid;

	always_comb begin
		mem_req = load_gnt ? load_req : fetch_req;
		mem_req.valid = load_gnt | fetch_gnt;
	end

endmodule

// File: imem_loader.sv
`timescale 1ns/1ps

module imem_loader import fetch_pkg::*; (
	input  logic            bus,
	input  logic            rst_n,
	input  axil_req_t       axil_req,
	output axil_rsp_t       axil_rsp,
	output imem_req_t       mem_req,
	input  logic            mem_gnt,
	input  logic [xlen-1:0] rdata
);

	typedef enum logic [2:0] {
		st_idle,
		st_wr_issue,
		st_wr_resp,
		st_rd_issue,
		st_rd_wait,
		st_rd_resp
	} ld_state_t;

	ld_state_t state, state_nxt;

	// captured transaction
	logic [imem_aw-1:0] addr_q;
	logic [xlen-1:0]    wdata_q;
	logic [3:0]         strb_q;
	logic [xlen-1:0]    rdata_q;

	// transfers this cycle
	logic wr_go;
	logic rd_go;

	////////////////////////////////////////////////////////////////////
	// axi side
	////////////////////////////////////////////////////////////////////

	// aw and w go together, write wins over read
	assign wr_go = (state == st_idle) & axil_req.aw_valid & axil_req.w_valid;
	assign rd_go = (state == st_idle) & axil_req.ar_valid & ~wr_go;

	always_comb begin
		axil_rsp.aw_ready = wr_go;
		axil_rsp.w_ready  = wr_go;
		axil_rsp.b_valid  = (state == st_wr_resp);
		axil_rsp.b_resp   = axi_okay;
		axil_rsp.ar_ready = rd_go;
		axil_rsp.r_valid  = (state == st_rd_wait) | (state == st_rd_resp);
		// memory word straight through first, held copy after
		axil_rsp.r_data   = (state == st_rd_wait) ? rdata : rdata_q;
		axil_rsp.r_resp   = axi_okay;
	end

	// memory side, held until granted
	always_comb begin
		mem_req.valid = (state == st_wr_issue) | (state == st_rd_issue);
		mem_req.write = (state == st_wr_issue);
		mem_req.addr  = addr_q;
		mem_req.wdata = wdata_q;
		mem_req.strb  = strb_q;
	end

	////////////////////////////////////////////////////////////////////
	// fsm
	////////////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (wr_go) state_nxt = st_wr_issue;
				else if (rd_go) state_nxt = st_rd_issue;
			end
			st_wr_issue: if (mem_gnt) state_nxt = st_wr_resp;
			st_wr_resp:  if (axil_req.b_ready) state_nxt = st_idle;
			st_rd_issue: if (mem_gnt) state_nxt = st_rd_wait;
			st_rd_wait:  state_nxt = axil_req.r_ready ? st_idle : st_rd_resp;
			st_rd_resp:  if (axil_req.r_ready) state_nxt = st_idle;
			default:     state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge bus or negedge rst_n) begin
		if (!rst_n) state <= st_idle;
		else state <= state_nxt;
	end

	// payload
	always_ff @(posedge bus) begin
		if (wr_go) begin
			addr_q  <= axil_req.aw_addr[imem_aw+1:2];
			wdata_q <= axil_req.w_data;
			strb_q  <= axil_req.w_strb;
		end else if (rd_go) begin
			addr_q  <= axil_req.ar_addr[imem_aw+1:2];
		end
		// keep the word for a stalled r
		if (state == st_rd_wait) rdata_q <= rdata;
	end

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; (
	input  logic            bus,
	input  logic            rst_n,
	input  logic            run,
	input  redirect_t       redirect,
	output imem_req_t       mem_req,
	input  logic            mem_gnt,
	input  logic [xlen-1:0] rdata,
	output fetch_out_t      out,
	output logic            out_valid,
	input  logic            out_ready
);

	// pc of the next instruction to hand out
	logic [xlen-1:0] pc_q, pc_nxt;
	// word address of the next word to read
	logic [xlen-3:0] faddr_q, faddr_sel;
	// upper halfword of the last word, always the halfword at pc_q
	logic [15:0] hbuf_q;
	logic        hbuf_v, hbuf_v_nxt;
	// fetched word parked while it cannot be used
	logic [xlen-1:0] wbuf_q;
	logic            wbuf_v;
	// our read was granted last cycle
	logic rd_pend;

	// current word, parked or just returned
	logic [xlen-1:0] cw;
	logic            cw_v;

	logic            out_free;
	logic            hold;
	logic            emit;
	logic            emit_comp;
	logic [xlen-1:0] emit_ins;
	logic            take_word;
	logic            can_issue;

	assign cw_v = wbuf_v | rd_pend;
	assign cw   = wbuf_v ? wbuf_q : rdata;

	assign out_free = ~out_valid | out_ready;
	// halfword and output full, no point reading ahead
	assign hold = hbuf_v & out_valid & ~out_ready;

	////////////////////////////////////////////////////////////////////
	// alignment
	////////////////////////////////////////////////////////////////////

	always_comb begin
		emit       = 1'b0;
		emit_comp  = 1'b0;
		emit_ins   = '0;
		take_word  = 1'b0;
		hbuf_v_nxt = hbuf_v;
		pc_nxt     = pc_q;
		if (hbuf_v && hbuf_q[1:0] != 2'b11) begin
			// compressed in the buffered upper half
			if (out_free) begin
				emit       = 1'b1;
				emit_comp  = 1'b1;
				emit_ins   = {16'h0, hbuf_q};
				hbuf_v_nxt = 1'b0;
				pc_nxt     = pc_q + 2;
			end
		end else if (hbuf_v) begin
			// straddle, joined with the low half of the new word
			if (cw_v && out_free) begin
				emit      = 1'b1;
				take_word = 1'b1;
				emit_ins  = {cw[15:0], hbuf_q};
				pc_nxt    = pc_q + 4;
			end
		end else if (cw_v && pc_q[1]) begin
			// odd target, low half is skipped
			take_word  = 1'b1;
			hbuf_v_nxt = 1'b1;
		end else if (cw_v && out_free) begin
			emit      = 1'b1;
			take_word = 1'b1;
			if (cw[1:0] != 2'b11) begin
				emit_comp  = 1'b1;
				emit_ins   = {16'h0, cw[15:0]};
				hbuf_v_nxt = 1'b1;
				pc_nxt     = pc_q + 2;
			end else begin
				emit_ins   = cw;
				hbuf_v_nxt = 1'b0;
				pc_nxt     = pc_q + 4;
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// word requests
	////////////////////////////////////////////////////////////////////

	// only when the word slot is free by the time data returns
	assign can_issue = (~cw_v | take_word) & ~hold;
	// a redirect reads its target in the same cycle
	assign faddr_sel = redirect.valid ? redirect.target[xlen-1:2] : faddr_q;

	always_comb begin
		mem_req.valid = run & (redirect.valid | can_issue);
		mem_req.write = 1'b0;
		mem_req.addr  = faddr_sel[imem_aw-1:0];
		mem_req.wdata = '0;
		mem_req.strb  = '0;
	end

	////////////////////////////////////////////////////////////////////
	// control state
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge bus or negedge rst_n) begin
		if (!rst_n) begin
			pc_q      <= '0;
			faddr_q   <= '0;
			hbuf_v    <= 1'b0;
			wbuf_v    <= 1'b0;
			rd_pend   <= 1'b0;
			out_valid <= 1'b0;
		end else if (!run) begin
			// parked at zero until run
			pc_q      <= '0;
			faddr_q   <= '0;
			hbuf_v    <= 1'b0;
			wbuf_v    <= 1'b0;
			rd_pend   <= 1'b0;
			out_valid <= 1'b0;
		end else if (redirect.valid) begin
			// flush everything, data of an older read is dropped
			pc_q      <= {redirect.target[xlen-1:1], 1'b0};
			faddr_q   <= faddr_sel + (xlen-2)'(mem_gnt);
			hbuf_v    <= 1'b0;
			wbuf_v    <= 1'b0;
			rd_pend   <= mem_gnt;
			out_valid <= 1'b0;
		end else begin
			pc_q    <= pc_nxt;
			faddr_q <= faddr_sel + (xlen-2)'(mem_gnt);
			hbuf_v  <= hbuf_v_nxt;
			wbuf_v  <= cw_v & ~take_word;
			rd_pend <= mem_gnt;
			if (emit) out_valid <= 1'b1;
			else if (out_ready) out_valid <= 1'b0;
		end
	end

	// payload
	always_ff @(posedge bus) begin
		if (take_word) hbuf_q <= cw[31:16];
		if (cw_v && !take_word) wbuf_q <= cw;
		if (emit) begin
			out.pc         <= pc_q;
			out.instr      <= emit_ins;
			out.compressed <= emit_comp;
		end
	end

endmodule

// File: fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
	input  logic       bus,
	input  logic       rst_n,
	input  axil_req_t  axil_req,
	output axil_rsp_t  axil_rsp,
	input  logic       run,
	input  redirect_t  redirect,
	output fetch_out_t ins,
	output logic       ins_valid,
	input  logic       ins_ready
);

	////////////////////////////////////////////////////////////////////
	// two peers on one memory port
	////////////////////////////////////////////////////////////////////

	imem_req_t       load_req;
	imem_req_t       fetch_req;
	imem_req_t       mem_req;
	logic            load_gnt;
	logic            fetch_gnt;
	// shared read return, each peer knows its own cycle
	logic [xlen-1:0] rdata;

	// program load and read back over axi
	imem_loader loader_i (
		.bus      (bus),
		.rst_n    (rst_n),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.mem_req  (load_req),
		.mem_gnt  (load_gnt),
		.rdata    (rdata)
	);

	imem_arbiter arb_i (
		.bus       (bus),
		.rst_n     (rst_n),
		.load_req  (load_req),
		.fetch_req (fetch_req),
		.load_gnt  (load_gnt),
		.fetch_gnt (fetch_gnt),
		.mem_req   (mem_req)
	);

	fetch_unit fetch_i (
		.bus       (bus),
		.rst_n     (rst_n),
		.run       (run),
		.redirect  (redirect),
		.mem_req   (fetch_req),
		.mem_gnt   (fetch_gnt),
		.rdata     (rdata),
		.out       (ins),
		.out_valid (ins_valid),
		.out_ready (ins_ready)
	);

	imem_ram ram_i (
		.bus   (bus),
		.req   (mem_req),
		.rdata (rdata)
	);

endmodule

// File: fetch_assertions.sv
`timescale 1ns/1ps

module fetch_assertions import fetch_pkg::*; (
	input logic       bus,
	input logic       rst_n,
	input axil_req_t  axil_req,
	input axil_rsp_t  axil_rsp,
	input logic       run,
	input redirect_t  redirect,
	input fetch_out_t ins,
	input logic       ins_valid,
	input logic       ins_ready
);

	////////////////////////////////////////////////////////////////////
	// fetch output handshake
	////////////////////////////////////////////////////////////////////

	// stalled instruction stays put
	ins_hold: assert property (@(posedge bus) disable iff (!rst_n)
		ins_valid && !ins_ready && !redirect.valid && run |=> ins_valid && $stable(ins))
		else $error("instruction output changed under back-pressure");

	// redirect withdraws whatever is shown
	ins_flush: assert property (@(posedge bus) disable iff (!rst_n)
		run && redirect.valid |=> !ins_valid)
		else $error("instruction still valid after a redirect");

	////////////////////////////////////////////////////////////////////
	// axi responses
	////////////////////////////////////////////////////////////////////

	// stalled r keeps valid and data
	r_hold: assert property (@(posedge bus) disable iff (!rst_n)
		axil_rsp.r_valid && !axil_req.r_ready |=> axil_rsp.r_valid && $stable(axil_rsp.r_data))
		else $error("axi read response dropped before acceptance");

	b_hold: assert property (@(posedge bus) disable iff (!rst_n)
		axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid)
		else $error("axi write response dropped before acceptance");

endmodule

bind fetch_top fetch_assertions assertions_i (.*);

// File: tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch import fetch_pkg::*; ();

	// load and read back near 3000 cycles, streams under 10000 with stalls
	localparam int max_cycles = 20000;

	logic       bus;
	logic       rst_n;
	axil_req_t  axil_req;
	axil_rsp_t  axil_rsp;
	logic       run;
	redirect_t  redirect;
	fetch_out_t ins;
	logic       ins_valid;
	logic       ins_ready;

	integer seed;
	int cycles = 0;
	// accepted instructions so far
	int accepted = 0;
	// model pc and the stall tracker
	logic [xlen-1:0] model_pc = '0;
	logic            held = 1'b0;
	fetch_out_t      held_ins;
	fetch_out_t      exp_ins;
	// byte image of the program
	logic [7:0] image [0:4*imem_words-1];

	fetch_top dut_i (
		.bus       (bus),
		.rst_n     (rst_n),
		.axil_req  (axil_req),
		.axil_rsp  (axil_rsp),
		.run       (run),
		.redirect  (redirect),
		.ins       (ins),
		.ins_valid (ins_valid),
		.ins_ready (ins_ready)
	);

	initial begin
		bus = 1'b0;
		forever #2 bus = ~bus;
	end

	////////////////////////////////////////////////////////////////////
	// failure reporting and run limit
	////////////////////////////////////////////////////////////////////

	task automatic give_up(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic mismatch(input string msg);
		give_up($sformatf("MISMATCH at %0t: %s", $time, msg));
	endtask

	always @(posedge bus) begin
		cycles++;
		if (cycles >= max_cycles)
			give_up($sformatf("timeout, the run did not end within %0d cycles", max_cycles));
	end

	////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] halfword(input logic [xlen-1:0] a);
		logic [9:0] b;
		// image wraps at the memory size
		b = a[9:0];
		return {image[b + 10'd1], image[b]};
	endfunction

	// low bits 11 mean a full 32-bit instruction
	function automatic fetch_out_t expected_at(input logic [xlen-1:0] pc);
		fetch_out_t e;
		logic [15:0] lo;
		logic [15:0] hi;
		lo = halfword(pc);
		hi = halfword(pc + 32'd2);
		e.pc = pc;
		e.compressed = (lo[1:0] != 2'b11);
		e.instr = e.compressed ? {16'h0, lo} : {hi, lo};
		return e;
	endfunction

	// sampled mid-cycle, what fires at the next rising edge
	always @(negedge bus) begin
		if (rst_n) begin
			if (held) begin
				assert (ins_valid && ins == held_ins)
				else mismatch("instruction changed or vanished while stalled");
			end
			held = run && ins_valid && !ins_ready && !redirect.valid;
			held_ins = ins;
			if (!run) begin
				model_pc = '0;
			end else if (redirect.valid) begin
				// shown instruction is dropped, not accepted
				model_pc = redirect.target;
			end else if (ins_valid && ins_ready) begin
				exp_ins = expected_at(model_pc);
				assert (ins == exp_ins)
				else mismatch($sformatf("pc %h instr %h c %0b, expected pc %h instr %h c %0b",
					ins.pc, ins.instr, ins.compressed,
					exp_ins.pc, exp_ins.instr, exp_ins.compressed));
				model_pc = model_pc + (exp_ins.compressed ? 32'd2 : 32'd4);
				accepted++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////

	// inputs change 1 ns after the edge
	task automatic sync();
		@(posedge bus);
		#1;
	endtask

	task automatic write_word(input int idx, input logic [xlen-1:0] data);
		logic [9:0] ba;
		int b;
		repeat ({$random(seed)} % 4) sync();
		axil_req.aw_valid = 1'b1;
		axil_req.aw_addr  = idx * 4;
		axil_req.w_valid  = 1'b1;
		axil_req.w_data   = data;
		axil_req.w_strb   = 4'hf;
		@(negedge bus);
		while (!(axil_rsp.aw_ready && axil_rsp.w_ready)) @(negedge bus);
		sync();
		axil_req.aw_valid = 1'b0;
		axil_req.w_valid  = 1'b0;
		// b ready toggles at random
		axil_req.b_ready = 1'($random(seed));
		@(negedge bus);
		while (!(axil_rsp.b_valid && axil_req.b_ready)) begin
			sync();
			axil_req.b_ready = 1'($random(seed));
			@(negedge bus);
		end
		assert (axil_rsp.b_resp == axi_okay)
		else mismatch($sformatf("write to word %0d answered %b", idx, axil_rsp.b_resp));
		sync();
		axil_req.b_ready = 1'b0;
		for (b = 0; b < 4; b++) begin
			ba = 10'(idx * 4 + b);
			image[ba] = data[8*b +: 8];
		end
	endtask

	task automatic read_word(input int idx);
		logic [xlen-1:0] word;
		logic [9:0] ba;
		repeat ({$random(seed)} % 4) sync();
		axil_req.ar_valid = 1'b1;
		axil_req.ar_addr  = idx * 4;
		axil_req.r_ready  = 1'($random(seed));
		@(negedge bus);
		while (!axil_rsp.ar_ready) @(negedge bus);
		sync();
		axil_req.ar_valid = 1'b0;
		@(negedge bus);
		while (!(axil_rsp.r_valid && axil_req.r_ready)) begin
			sync();
			axil_req.r_ready = 1'($random(seed));
			@(negedge bus);
		end
		ba = 10'(idx * 4);
		word = {image[ba + 10'd3], image[ba + 10'd2], image[ba + 10'd1], image[ba]};
		assert (axil_rsp.r_data == word && axil_rsp.r_resp == axi_okay)
		else mismatch($sformatf("read of word %0d gave %h resp %b, expected %h",
			idx, axil_rsp.r_data, axil_rsp.r_resp, word));
		sync();
		axil_req.r_ready = 1'b0;
	endtask

	// random back-pressure and redirects until n more are accepted
	task automatic drive_stream(input int n, input bit redirects);
		int goal;
		goal = accepted + n;
		while (accepted < goal) begin
			ins_ready = ($random(seed) & 3) != 0;
			redirect = '0;
			if (redirects && ({$random(seed)} % 32 == 0)) begin
				redirect.valid  = 1'b1;
				redirect.target = ({$random(seed)} % 512) * 2;
				// often lands on an acceptance
				ins_ready = 1'b1;
			end
			sync();
		end
		ins_ready = 1'b0;
		redirect = '0;
	endtask

	// loader reads competing with fetch
	task automatic read_during_fetch(input int n);
		int k;
		for (k = 0; k < n; k++) begin
			repeat ({$random(seed)} % 16) sync();
			read_word({$random(seed)} % imem_words);
		end
	endtask

	initial begin
		int i;
		seed = 59;
		rst_n = 1'b0;
		run = 1'b0;
		redirect = '0;
		axil_req = '0;
		ins_ready = 1'b0;
		repeat (10) @(posedge bus);
		#1;
		rst_n = 1'b1;
		// program load, then every word read back
		for (i = 0; i < imem_words; i++) begin
			write_word(i, $random(seed));
		end
		for (i = 0; i < imem_words; i++) begin
			read_word(i);
		end
		// sequential stream with stalls, no redirects
		run = 1'b1;
		drive_stream(400, 1'b0);
		// redirects while the loader reads
		fork
			drive_stream(1100, 1'b1);
			read_during_fetch(64);
		join
		// rewrite the start of the program while parked
		run = 1'b0;
		repeat (3) sync();
		for (i = 0; i < 32; i++) begin
			write_word(i, $random(seed));
		end
		run = 1'b1;
		drive_stream(300, 1'b0);
		run = 1'b0;
		repeat (3) sync();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: sim.f
fetch_pkg.sv
imem_ram.sv
imem_arbiter.sv
imem_loader.sv
fetch_unit.sv
fetch_top.sv
fetch_assertions.sv
tb_fetch.sv

// File: Makefile
TOP = tb_fetch

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
